// File: Bender.yml
package:
  name: u1plus_core

export_include_dirs:
  - include

sources:
  - design/core_pkg.sv
  - design/wb_intercon.sv
  - design/misc_regs.sv
  - design/settings_bus_16le.sv
  - design/vita_time_64.sv
  - design/u1plus_core_top.sv
  - target: test
    files:
      - dv/u1plus_core_assertions.sv
      - dv/tb_u1plus_core.sv

// File: design/core_pkg.sv
/* radio core shared types */

`include "core_macros.svh"

package core_pkg;

   // slot and offset view of a bus address
   typedef struct packed
   {
      logic [`U1P_SLOT_W-1:0]          slot;     // picks one of 16 slaves
      logic [`U1P_AW-`U1P_SLOT_W-1:0]  offset;   // byte address inside slave
   } wb_addr_fld_t;

   // same 11 bits, read either as a plain word or split for decode
   typedef union packed
   {
      logic [`U1P_AW-1:0]  raw;
      wb_addr_fld_t        fld;
   } wb_addr_u;

   ////////////////////
   // settings bus

   typedef logic [7:0]  set_addr_t;   // register index
   typedef logic [31:0] set_data_t;   // one full settings word

   ////////////////////
   // vita time
   // seconds in [63:32], ticks in [31:0]

   typedef logic [63:0] vita_time_t;

endpackage

// File: design/misc_regs.sv
/* board control and status registers */

`timescale 1ns/10ps

`include "core_macros.svh"

module misc_regs
  (input  logic                            wb_clk,
   input  logic                            wb_rst,
   input  logic [`U1P_AW-`U1P_SLOT_W-1:0]  adr_i,
   input  logic [`U1P_DW-1:0]              dat_i,
   input  logic                            we_i,
   input  logic                            cyc_i,
   input  logic                            stb_i,
   output logic [`U1P_DW-1:0]              dat_o,
   output logic                            ack_o,
   input  logic [2:0]                      cgen_st_i,       // status, ld, refmon
   output logic                            cgen_sync_b_o,
   output logic                            cgen_ref_sel_o,
   output logic [2:0]                      debug_led_o);

   logic [`U1P_DW-1:0] reg_leds;
   logic [`U1P_DW-1:0] reg_cgen_ctrl;
   logic [`U1P_DW-1:0] reg_test;
   logic               wr;

   assign wr    = cyc_i & stb_i & we_i;
   assign ack_o = cyc_i & stb_i;    // no wait states

   ////////////////////
   // write side

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'd3;   // sync_b high, ref_sel high
         reg_test      <= '0;
      end
      else if (wr)
      begin
         case (adr_i)
            `U1P_REG_LEDS      : reg_leds      <= dat_i;
            `U1P_REG_CGEN_CTRL : reg_cgen_ctrl <= dat_i;
            `U1P_REG_TEST      : reg_test      <= dat_i;
            default            : ;               // status and unknown offsets ignore writes
         endcase
      end
   end

   ////////////////////
   // read side

   always_comb
   begin
      case (adr_i)
         `U1P_REG_LEDS      : dat_o = reg_leds;
         `U1P_REG_CGEN_CTRL : dat_o = reg_cgen_ctrl;
         `U1P_REG_CGEN_ST   : dat_o = {{(`U1P_DW-3){1'b0}}, cgen_st_i};
         `U1P_REG_TEST      : dat_o = reg_test;
         default            : dat_o = `U1P_DEFAULT_RD;
      endcase
   end

   // leds 0 and 1 are swapped on the board
   assign debug_led_o = {reg_leds[2], reg_leds[0], reg_leds[1]};

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

endmodule

// File: design/settings_bus_16le.sv
/* 16 bit wishbone to settings bus */

`timescale 1ns/10ps

`include "core_macros.svh"

module settings_bus_16le
  (input  logic                            wb_clk,
   input  logic                            wb_rst,
   input  logic [`U1P_AW-`U1P_SLOT_W-1:0]  adr_i,     // [6:2] index, [1] half
   input  logic [`U1P_DW-1:0]              dat_i,
   input  logic                            we_i,
   input  logic                            cyc_i,
   input  logic                            stb_i,
   output logic [`U1P_DW-1:0]              dat_o,
   output logic                            ack_o,
   output logic                            set_stb_o,
   output core_pkg::set_addr_t             set_addr_o,
   output core_pkg::set_data_t             set_data_o);

   logic [`U1P_DW-1:0] low_q;   // low half waiting for its partner
   logic               wr;
   logic               wr_hi;

   assign wr    = cyc_i & stb_i & we_i;
   assign wr_hi = wr & adr_i[1];

   assign ack_o = cyc_i & stb_i;
   assign dat_o = '0;             // write only port

   always_ff @(posedge wb_clk)
   begin
      if (wr && !adr_i[1])
         low_q <= dat_i;
   end

   // high half completes the word, strobe goes out next cycle
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_hi;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
      begin
         set_addr_o <= {3'b000, adr_i[6:2]};
         set_data_o <= {dat_i, low_q};
      end
   end

endmodule

// File: design/u1plus_core_top.sv
/* radio core control plane */

`timescale 1ns/10ps

`include "core_macros.svh"

module u1plus_core_top
  #(parameter int unsigned TICKS_PER_SEC = `U1P_TICKS_PER_SEC)
   (input  logic                     wb_clk,
    input  logic                     wb_rst,
    // host wishbone master
    input  core_pkg::wb_addr_u       wb_adr_i,
    input  logic [`U1P_DW-1:0]       wb_dat_i,
    input  logic [`U1P_SW-1:0]       wb_sel_i,
    input  logic                     wb_we_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    output logic [`U1P_DW-1:0]       wb_dat_o,
    output logic                     wb_ack_o,
    // clock generator
    input  logic                     cgen_st_status_i,
    input  logic                     cgen_st_ld_i,
    input  logic                     cgen_st_refmon_i,
    output logic                     cgen_sync_b_o,
    output logic                     cgen_ref_sel_o,
    output logic [2:0]               debug_led_o,
    // timing
    input  logic                     pps_i,
    output logic                     pps_int_o,
    output core_pkg::vita_time_t     vita_time_o);

   import core_pkg::*;

   // shared slave side of the interconnect
   logic [`U1P_AW-`U1P_SLOT_W-1:0] s_adr;
   logic [`U1P_DW-1:0]              s_dat;
   logic                            s_we;

   logic [`U1P_DW-1:0]              misc_dat;
   logic                            misc_cyc;
   logic                            misc_stb;
   logic                            misc_ack;

   logic [`U1P_DW-1:0]              sb_dat;    // settings slave, wishbone side
   logic                            sb_cyc;
   logic                            sb_stb;
   logic                            sb_ack;

   // settings bus
   logic                            set_stb;
   set_addr_t                       set_addr;
   set_data_t                       set_data;

   ////////////////////
   // interconnect

   wb_intercon i_wb_intercon
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_adr_i(wb_adr_i), .m_dat_i(wb_dat_i), .m_sel_i(wb_sel_i), .m_we_i(wb_we_i),
      .m_cyc_i(wb_cyc_i), .m_stb_i(wb_stb_i), .m_dat_o(wb_dat_o), .m_ack_o(wb_ack_o),
      .s_adr_o(s_adr), .s_dat_o(s_dat), .s_we_o(s_we),
      .misc_cyc_o(misc_cyc), .misc_stb_o(misc_stb), .misc_dat_i(misc_dat),
      .misc_ack_i(misc_ack),
      .set_cyc_o(sb_cyc), .set_stb_o(sb_stb), .set_dat_i(sb_dat), .set_ack_i(sb_ack));

   ////////////////////
   // slave 0, board control

   misc_regs i_misc_regs
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(s_adr), .dat_i(s_dat), .we_i(s_we), .cyc_i(misc_cyc), .stb_i(misc_stb),
      .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_i({cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i}),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .debug_led_o(debug_led_o));

   ////////////////////
   // slave 5, settings bus

   settings_bus_16le i_settings_bus_16le
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(s_adr), .dat_i(s_dat), .we_i(s_we), .cyc_i(sb_cyc), .stb_i(sb_stb),
      .dat_o(sb_dat), .ack_o(sb_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////
   // vita timekeeper

   vita_time_64 #(.TICKS_PER_SEC(TICKS_PER_SEC), .BASE(`U1P_SR_TIME64)) i_vita_time_64
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .pps_int_o(pps_int_o), .vita_time_o(vita_time_o));

endmodule

// File: design/vita_time_64.sv
/* 64 bit vita timekeeper */

`timescale 1ns/10ps

`include "core_macros.svh"

module vita_time_64
  #(parameter int unsigned         TICKS_PER_SEC = `U1P_TICKS_PER_SEC,
    parameter core_pkg::set_addr_t BASE          = `U1P_SR_TIME64)
   (input  logic                 wb_clk,
    input  logic                 wb_rst,
    input  logic                 set_stb_i,
    input  core_pkg::set_addr_t  set_addr_i,
    input  core_pkg::set_data_t  set_data_i,
    input  logic                 pps_i,
    output logic                 pps_int_o,     // one cycle per pps rise
    output core_pkg::vita_time_t vita_time_o);

   import core_pkg::*;

   localparam set_addr_t   ADDR_SECS  = BASE;
   localparam set_addr_t   ADDR_TICKS = BASE + 8'd1;
   localparam set_addr_t   ADDR_CTRL  = BASE + 8'd2;
   localparam logic [31:0] TICK_LAST  = TICKS_PER_SEC - 1;

   logic        pps_s1;
   logic        pps_s2;
   logic        pps_s2_d;
   logic [31:0] pend_secs;
   logic [31:0] pend_ticks;
   logic [31:0] secs;
   logic [31:0] ticks;
   logic        armed;       // load waits for next pps
   logic        ctrl_wr;
   logic        load_now;
   logic        load_pps;

   ////////////////////
   // pps sync and edge detect

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_s1    <= 1'b0;
         pps_s2    <= 1'b0;
         pps_s2_d  <= 1'b0;
         pps_int_o <= 1'b0;
      end
      else
      begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_s2_d  <= pps_s2;
         pps_int_o <= pps_s2 & ~pps_s2_d;
      end
   end

   ////////////////////
   // settings decode

   assign ctrl_wr  = set_stb_i && (set_addr_i == ADDR_CTRL);
   assign load_now = ctrl_wr && set_data_i[0];
   assign load_pps = pps_int_o && armed;

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == ADDR_SECS))
         pend_secs <= set_data_i;
      if (set_stb_i && (set_addr_i == ADDR_TICKS))
         pend_ticks <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         armed <= 1'b0;
      else if (ctrl_wr && !set_data_i[0])
         armed <= 1'b1;
      else if (load_pps)
         armed <= 1'b0;   // one shot
   end

   ////////////////////
   // counter

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
      end
      else if (load_now || load_pps)
      begin
         secs  <= pend_secs;
         ticks <= pend_ticks;
      end
      else if (ticks == TICK_LAST)
      begin
         ticks <= '0;
         secs  <= secs + 32'd1;
      end
      else
         ticks <= ticks + 32'd1;
   end

   assign vita_time_o = {secs, ticks};

endmodule

// File: design/wb_intercon.sv
/* single master wishbone decoder */

`timescale 1ns/10ps

`include "core_macros.svh"

module wb_intercon
  (input  logic                            wb_clk,
   input  logic                            wb_rst,
   // master side
   input  core_pkg::wb_addr_u              m_adr_i,
   input  logic [`U1P_DW-1:0]              m_dat_i,
   input  logic [`U1P_SW-1:0]              m_sel_i,
   input  logic                            m_we_i,
   input  logic                            m_cyc_i,
   input  logic                            m_stb_i,
   output logic [`U1P_DW-1:0]              m_dat_o,
   output logic                            m_ack_o,
   // shared to all slaves
   output logic [`U1P_AW-`U1P_SLOT_W-1:0]  s_adr_o,
   output logic [`U1P_DW-1:0]              s_dat_o,
   output logic                            s_we_o,
   // slot 0
   output logic                            misc_cyc_o,
   output logic                            misc_stb_o,
   input  logic [`U1P_DW-1:0]              misc_dat_i,
   input  logic                            misc_ack_i,
   // slot 5
   output logic                            set_cyc_o,
   output logic                            set_stb_o,
   input  logic [`U1P_DW-1:0]              set_dat_i,
   input  logic                            set_ack_i);

   import core_pkg::*;

   wb_addr_u adr_q;      // address held over a stalled strobe
   wb_addr_u adr_cur;
   logic     lock_q;
   logic     lanes;      // at least one byte lane enabled
   logic     misc_hit;
   logic     set_hit;

   // a strobe nobody acks keeps its target even if the master moves the address
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         lock_q <= 1'b0;
      else
         lock_q <= m_cyc_i & m_stb_i & ~m_ack_o;
   end

   always_ff @(posedge wb_clk)
      adr_q <= adr_cur;

   assign adr_cur = lock_q ? adr_q : m_adr_i;

   ////////////////////
   // decode

   assign lanes    = |m_sel_i;
   assign misc_hit = (adr_cur.fld.slot == `U1P_SLOT_MISC);
   assign set_hit  = (adr_cur.fld.slot == `U1P_SLOT_SETTINGS);

   assign s_adr_o = adr_cur.fld.offset;
   assign s_dat_o = m_dat_i;
   assign s_we_o  = m_we_i;

   assign misc_cyc_o = m_cyc_i & misc_hit;
   assign misc_stb_o = m_stb_i & lanes & misc_hit;
   assign set_cyc_o  = m_cyc_i & set_hit;
   assign set_stb_o  = m_stb_i & lanes & set_hit;

   // read data and ack back to the master, empty slots stay silent
   always_comb
   begin
      case (adr_cur.fld.slot)
         `U1P_SLOT_MISC :
         begin
            m_dat_o = misc_dat_i;
            m_ack_o = misc_ack_i;
         end
         `U1P_SLOT_SETTINGS :
         begin
            m_dat_o = set_dat_i;
            m_ack_o = set_ack_i;
         end
         default :
         begin
            m_dat_o = '0;
            m_ack_o = 1'b0;
         end
      endcase
   end

endmodule

// File: dv/tb_u1plus_core.sv
/* radio core control plane testbench */

`timescale 1ns/10ps

`include "core_macros.svh"

module tb_u1plus_core;

   import core_pkg::*;

   localparam int unsigned TPS       = 10;     // fast rollover
   localparam int          TIMEOUT   = 50;     // cycles allowed per wait
   localparam logic [4:0]  IDX_SECS  = 5'(`U1P_SR_TIME64);
   localparam logic [4:0]  IDX_TICKS = 5'(`U1P_SR_TIME64 + 8'd1);
   localparam logic [4:0]  IDX_CTRL  = 5'(`U1P_SR_TIME64 + 8'd2);

   logic               wb_clk;
   logic               wb_rst;
   wb_addr_u           wb_adr;
   logic [`U1P_DW-1:0] wb_dat;
   logic [`U1P_SW-1:0] wb_sel;
   logic               wb_we;
   logic               wb_cyc;
   logic               wb_stb;
   logic [`U1P_DW-1:0] wb_dat_o;
   logic               wb_ack_o;
   logic [2:0]         cgen_st;        // status, ld, refmon
   logic               cgen_sync_b;
   logic               cgen_ref_sel;
   logic [2:0]         debug_led;
   logic               pps;
   logic               pps_int;
   vita_time_t         vita_time;

   ////////////////////
   // reference model state

   vita_time_t         ref_pend;
   logic               ref_armed;
   int                 imm_cnt;        // samples until an immediate load lands
   int                 pps_cnt;        // samples until a pps load lands
   int                 err_cnt;
   integer             seed;

   u1plus_core_top #(.TICKS_PER_SEC(TPS)) i_u1plus_core_top
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat),
      .wb_sel_i(wb_sel), .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cgen_st_status_i(cgen_st[2]), .cgen_st_ld_i(cgen_st[1]), .cgen_st_refmon_i(cgen_st[0]),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel), .debug_led_o(debug_led),
      .pps_i(pps), .pps_int_o(pps_int), .vita_time_o(vita_time));

   initial
   begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   // expected time one clock later
   function automatic vita_time_t next_time(input vita_time_t t, input logic load,
                                            input vita_time_t pend);
      if (load)
         return pend;
      if (t[31:0] == TPS - 1)
         return {t[63:32] + 32'd1, 32'd0};   // ticks wrap into seconds
      return {t[63:32], t[31:0] + 32'd1};
   endfunction

   // led pins as wired on the board
   function automatic logic [2:0] led_pins(input logic [15:0] v);
      logic [2:0] p;
      p    = v[2:0];
      p[0] = v[1];   // leds 0 and 1 exchanged
      p[1] = v[0];
      return p;
   endfunction

   task automatic report_fail(input string what);
      err_cnt++;
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] expv, input logic [63:0] got);
      assert (got === expv)
      else report_fail($sformatf("[FAIL] %0t ns %s expected %0h got %0h",
                                 $time, name, expv, got));
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   // one wishbone cycle entered and left 1 ns after a rising edge
   task automatic bus_cycle(input logic [`U1P_AW-1:0] adr, input logic we,
                            input logic [15:0] wdat, output logic [15:0] rdat);
      int n;
      n          = 0;
      wb_adr.raw = adr;
      wb_dat     = wdat;
      wb_we      = we;
      wb_cyc     = 1'b1;
      wb_stb     = 1'b1;
      @(negedge wb_clk);
      while (!wb_ack_o)
      begin
         n++;
         if (n > TIMEOUT)
            report_fail("timeout: the bus never acknowledged the cycle");
         else
            @(negedge wb_clk);
      end
      rdat = wb_dat_o;
      @(posedge wb_clk);          // write lands on this edge
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic misc_write(input logic [6:0] off, input logic [15:0] d);
      logic [15:0] unused;
      bus_cycle({`U1P_SLOT_MISC, off}, 1'b1, d, unused);
   endtask

   task automatic misc_read_check(input string name, input logic [6:0] off,
                                  input logic [15:0] expv);
      logic [15:0] got;
      bus_cycle({`U1P_SLOT_MISC, off}, 1'b0, 16'h0000, got);
      check_val(name, 64'(expv), 64'(got));
   endtask

   // low half first and the high half fires the settings strobe
   task automatic set_write(input logic [4:0] idx, input logic [31:0] d);
      logic [15:0] unused;
      bus_cycle({`U1P_SLOT_SETTINGS, idx, 2'b00}, 1'b1, d[15:0], unused);
      bus_cycle({`U1P_SLOT_SETTINGS, idx, 2'b10}, 1'b1, d[31:16], unused);
   endtask

   task automatic load_time(input vita_time_t t, input logic now);
      set_write(IDX_SECS, t[63:32]);
      set_write(IDX_TICKS, t[31:0]);
      ref_pend = t;
      set_write(IDX_CTRL, {31'd0, now});
      if (now)
         imm_cnt = 2;             // strobe next cycle then load on the edge after
      else
         ref_armed = 1'b1;
   endtask

   task automatic pulse_pps();
      pps = 1'b1;
      if (ref_armed)
      begin
         pps_cnt   = 5;           // two sync flops and edge detect before the load
         ref_armed = 1'b0;
      end
      idle(4);
      pps = 1'b0;
   endtask

   ////////////////////
   // time compare sampled mid cycle

   initial
   begin : compare_time
      vita_time_t prev;
      vita_time_t expt;
      logic       rst_edge;
      logic       due;
      prev = '0;
      forever
      begin
         @(posedge wb_clk);
         rst_edge = wb_rst;
         @(negedge wb_clk);
         due = 1'b0;
         if (imm_cnt > 0)
         begin
            imm_cnt--;
            due = (imm_cnt == 0);
         end
         if (pps_cnt > 0)
         begin
            pps_cnt--;
            if (pps_cnt == 1)
               check_val("pps_int_o", 64'd1, 64'(pps_int));
            due = due | (pps_cnt == 0);
         end
         expt = rst_edge ? '0 : next_time(prev, due, ref_pend);
         check_val("vita_time_o", expt, vita_time);
         prev = vita_time;
      end
   end

   initial
   begin : stimulus
      logic [15:0] r;
      logic [31:0] secs;
      logic [31:0] tk;
      seed       = 32'h79a8;
      err_cnt    = 0;
      imm_cnt    = 0;
      pps_cnt    = 0;
      ref_armed  = 1'b0;
      ref_pend   = '0;
      wb_rst     = 1'b1;
      wb_adr.raw = '0;
      wb_dat     = '0;
      wb_sel     = 2'b11;
      wb_we      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      cgen_st    = 3'b000;
      pps        = 1'b0;
      repeat (5) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      // reset values
      misc_read_check("leds", `U1P_REG_LEDS, 16'h0000);
      misc_read_check("cgen_ctrl", `U1P_REG_CGEN_CTRL, 16'h0003);
      check_val("debug_led_o", 64'd0, 64'(debug_led));
      check_val("cgen_sync_b_o", 64'd1, 64'(cgen_sync_b));
      check_val("cgen_ref_sel_o", 64'd1, 64'(cgen_ref_sel));

      // fixed patterns where bits 0 and 1 differ
      misc_write(`U1P_REG_LEDS, 16'h0001);
      check_val("debug_led_o", 64'd2, 64'(debug_led));
      misc_write(`U1P_REG_LEDS, 16'h0006);
      check_val("debug_led_o", 64'd5, 64'(debug_led));
      misc_write(`U1P_REG_CGEN_CTRL, 16'h0002);
      check_val("cgen_sync_b_o", 64'd1, 64'(cgen_sync_b));
      check_val("cgen_ref_sel_o", 64'd0, 64'(cgen_ref_sel));
      cgen_st = 3'b100;           // status pin alone
      misc_read_check("cgen_status", `U1P_REG_CGEN_ST, 16'h0004);

      repeat (4)
      begin
         r = 16'($random(seed));
         misc_write(`U1P_REG_LEDS, r);
         misc_read_check("leds", `U1P_REG_LEDS, r);
         check_val("debug_led_o", 64'(led_pins(r)), 64'(debug_led));
         r = 16'($random(seed));
         misc_write(`U1P_REG_CGEN_CTRL, r);
         misc_read_check("cgen_ctrl", `U1P_REG_CGEN_CTRL, r);
         check_val("cgen_sync_b_o", 64'(r[1]), 64'(cgen_sync_b));
         check_val("cgen_ref_sel_o", 64'(r[0]), 64'(cgen_ref_sel));
         r = 16'($random(seed));
         misc_write(`U1P_REG_TEST, r);
         misc_read_check("test", `U1P_REG_TEST, r);
         cgen_st = 3'($random(seed));
         misc_read_check("cgen_status", `U1P_REG_CGEN_ST, {13'd0, cgen_st});
      end
      misc_read_check("offset 2", 7'd2, `U1P_DEFAULT_RD);

      idle(35);                   // a few seconds of rollover

      // immediate load
      secs = $random(seed);
      tk   = $unsigned($random(seed)) % TPS;
      load_time({secs, tk}, 1'b1);
      idle(15);

      // armed load with pps withheld for a while
      secs = $random(seed);
      tk   = $unsigned($random(seed)) % TPS;
      load_time({secs, tk}, 1'b0);
      idle(20);
      pulse_pps();
      idle(12);
      pulse_pps();                // arm already spent
      idle(12);

      if (err_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: dv/u1plus_core_assertions.sv
/* bound timekeeper checks */

`timescale 1ns/10ps

`include "core_macros.svh"

module u1plus_core_assertions
  #(parameter int unsigned TICKS_PER_SEC = `U1P_TICKS_PER_SEC)
   (input logic        wb_clk,
    input logic        wb_rst,
    input logic        set_stb_i,
    input logic        pps_i,
    input logic        pps_int_o,
    input logic [63:0] vita_time_o);

   // one strobe per completed settings word
   strobe_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                    set_stb_i |=> !set_stb_i)
      else $error("settings strobe lasted two cycles");

   // pulse only three edges after a pps rise so never two wide
   pps_one_cycle : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                    pps_int_o |-> $past(pps_i, 3) && !$past(pps_i, 4))
      else $error("pps pulse not one cycle three edges after the rise");

   ticks_range : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                  vita_time_o[31:0] < TICKS_PER_SEC)
      else $error("ticks reached the tick rate");

endmodule

bind vita_time_64 u1plus_core_assertions #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_u1plus_core_assertions
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i), .pps_i(pps_i),
   .pps_int_o(pps_int_o), .vita_time_o(vita_time_o));

// File: files.f
+incdir+include
design/core_pkg.sv
design/wb_intercon.sv
design/misc_regs.sv
design/settings_bus_16le.sv
design/vita_time_64.sv
design/u1plus_core_top.sv
dv/u1plus_core_assertions.sv
dv/tb_u1plus_core.sv

// File: include/core_macros.svh
/* radio core build constants */

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

////////////////////
// wishbone geometry

`define U1P_DW              16   // data width
`define U1P_AW              11   // address width
`define U1P_SW              2    // byte selects
`define U1P_SLOT_W          4    // upper address bits that pick a slave

////////////////////
// slave slots

`define U1P_SLOT_MISC       4'd0
`define U1P_SLOT_SETTINGS   4'd5

////////////////////
// misc register offsets, byte addressed

`define U1P_REG_LEDS        7'd0
`define U1P_REG_CGEN_CTRL   7'd4
`define U1P_REG_CGEN_ST     7'd6   // read only
`define U1P_REG_TEST        7'd8

// returned for any offset not decoded
`define U1P_DEFAULT_RD      16'hBEEF

////////////////////
// settings bus map and timing

`define U1P_SR_TIME64       8'd28          // 3 regs used
`define U1P_TICKS_PER_SEC   32'd64000000   // 64 MHz master clock

`endif
